// ==== Bender.yml ====
package:
  name: desc64_frontend

sources:
  - source/desc64_pkg.sv
  - source/dma_req_pkg.sv
  - source/desc64_reshaper.sv
  - source/desc64_fetcher.sv
  - source/desc64_chain_ctrl.sv
  - source/desc64_frontend.sv
  - target: test
    files:
      - verification/tb_desc64_frontend.sv

// ==== all.f ====
source/desc64_pkg.sv
source/dma_req_pkg.sv
source/desc64_reshaper.sv
source/desc64_fetcher.sv
source/desc64_chain_ctrl.sv
source/desc64_frontend.sv
verification/tb_desc64_frontend.sv

// ==== source/desc64_chain_ctrl.sv ====
// ----------------------------------------------------------------------
// chain controller FSM
// doorbell, fetch, request issue, completion, irq and next pointer walk
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module desc64_chain_ctrl (
    input  wire                    clk_i,
    input  wire                    rst_n_i,
    input  wire                    doorbell_i,
    input  wire desc64_pkg::addr_t doorbell_addr_i,
    output logic                   busy_o,
    output logic                   fetch_start_o,
    output desc64_pkg::addr_t      fetch_addr_o,
    input  wire                    desc_valid_i,
    input  wire desc64_pkg::addr_t next_addr_i,
    input  wire                    do_irq_i,
    output logic                   be_req_valid_o,
    input  wire                    be_done_i,
    output logic                   irq_o
);
    import desc64_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        ISSUE,
        WAIT_DONE
    } state_e;

    state_e state_q;

    // current descriptor address, next pointer and irq flag
    addr_t desc_addr_q;
    addr_t next_q;
    logic  irq_flag_q;

    logic fetch_start_q;
    logic irq_q;

    // events the FSM reacts to
    logic doorbell_acc;
    logic desc_acc;
    logic done_acc;
    logic chain_end;

    // strobe only counts while idle and is dropped otherwise
    assign doorbell_acc = (state_q == IDLE) && doorbell_i;
    assign desc_acc     = (state_q == FETCH) && desc_valid_i;
    assign done_acc     = (state_q == WAIT_DONE) && be_done_i;
    assign chain_end    = (next_q == END_OF_CHAIN);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q       <= IDLE;
            fetch_start_q <= 1'b0;
            irq_q         <= 1'b0;
        end else begin
            fetch_start_q <= 1'b0;
            irq_q         <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (doorbell_acc) begin
                        state_q       <= FETCH;
                        fetch_start_q <= 1'b1;
                    end
                end
                FETCH: begin
                    if (desc_acc) begin
                        state_q <= ISSUE;
                    end
                end
                // single cycle state that drives the request pulse
                ISSUE: begin
                    state_q <= WAIT_DONE;
                end
                WAIT_DONE: begin
                    if (done_acc) begin
                        irq_q <= irq_flag_q;
                        if (chain_end) begin
                            state_q <= IDLE;
                        end else begin
                            state_q       <= FETCH;
                            fetch_start_q <= 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // address and captured descriptor info
    // reshaper outputs may move after desc_valid, so keep a copy
    always_ff @(posedge clk_i) begin
        if (doorbell_acc) begin
            desc_addr_q <= doorbell_addr_i;
        end else if (done_acc) begin
            desc_addr_q <= next_q;
        end
        if (desc_acc) begin
            next_q     <= next_addr_i;
            irq_flag_q <= do_irq_i;
        end
    end

    assign busy_o         = (state_q != IDLE);
    assign fetch_start_o  = fetch_start_q;
    assign fetch_addr_o   = desc_addr_q;
    assign be_req_valid_o = (state_q == ISSUE);
    assign irq_o          = irq_q;

    // backend completes only a request it was given
    a_done_in_wait : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        be_done_i |-> (state_q == WAIT_DONE))
        else $error("chain ctrl: backend done without an outstanding request");

endmodule

`default_nettype wire

// ==== source/desc64_fetcher.sv ====
// ----------------------------------------------------------------------
// descriptor fetcher
// four sequential word reads, one outstanding, assembled into a register
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module desc64_fetcher (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     fetch_start_i,
    input  wire desc64_pkg::addr_t  fetch_addr_i,
    output logic                    mem_req_o,
    output desc64_pkg::addr_t       mem_addr_o,
    input  wire                     mem_rvalid_i,
    input  wire desc64_pkg::word_t  mem_rdata_i,
    output logic                    desc_valid_o,
    output desc64_pkg::descriptor_t descriptor_o
);
    import desc64_pkg::*;

    // descriptor base and held descriptor
    addr_t       base_q;
    descriptor_t desc_q;

    // fetch control
    word_idx_t word_cnt_q;
    logic      active_q;
    logic      pending_q;
    logic      req_q;
    logic      valid_q;
    logic      last_word;

    assign last_word = (word_cnt_q == word_idx_t'(DESC_WORDS - 1));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            word_cnt_q <= '0;
            active_q   <= 1'b0;
            pending_q  <= 1'b0;
            req_q      <= 1'b0;
            valid_q    <= 1'b0;
        end else begin
            // request and valid are single cycle pulses
            req_q   <= 1'b0;
            valid_q <= 1'b0;
            // first read goes out the cycle after start
            if (fetch_start_i) begin
                active_q   <= 1'b1;
                word_cnt_q <= '0;
                req_q      <= 1'b1;
            end
            // read is open from the request until its data returns
            if (req_q) begin
                pending_q <= 1'b1;
            end
            if (mem_rvalid_i) begin
                pending_q <= 1'b0;
                if (last_word) begin
                    active_q <= 1'b0;
                    valid_q  <= 1'b1;
                end else begin
                    // next word right behind the returned one
                    word_cnt_q <= word_cnt_q + word_idx_t'(1);
                    req_q      <= 1'b1;
                end
            end
        end
    end

    // base and descriptor words
    always_ff @(posedge clk_i) begin
        if (fetch_start_i) begin
            base_q <= fetch_addr_i;
        end
        if (mem_rvalid_i) begin
            desc_q[word_cnt_q*WORD_W +: WORD_W] <= mem_rdata_i;
        end
    end

    // word k lives at base + k * 8
    assign mem_addr_o   = base_q + addr_t'(word_cnt_q) * addr_t'(WORD_BYTES);
    assign mem_req_o    = req_q;
    assign desc_valid_o = valid_q;
    // held until the next fetch overwrites it
    assign descriptor_o = desc_q;

    // read data only answers an open read
    a_rvalid_pending : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rvalid_i |-> pending_q)
        else $error("fetcher: read data without an open read");

    // no restart while a descriptor is still being collected
    a_start_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_start_i |-> !active_q)
        else $error("fetcher: fetch start during an active fetch");

endmodule

`default_nettype wire

// ==== source/desc64_frontend.sv ====
// ----------------------------------------------------------------------
// descriptor chain DMA frontend top level
// fetcher, reshaper and chain controller
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module desc64_frontend (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    // doorbell
    input  wire                       doorbell_i,
    input  wire desc64_pkg::addr_t    doorbell_addr_i,
    output logic                      busy_o,
    // memory read port
    output logic                      mem_req_o,
    output desc64_pkg::addr_t         mem_addr_o,
    input  wire                       mem_rvalid_i,
    input  wire desc64_pkg::word_t    mem_rdata_i,
    // backend request
    output logic                      be_req_valid_o,
    output dma_req_pkg::req_length_t  be_length_o,
    output dma_req_pkg::req_addr_t    be_src_addr_o,
    output dma_req_pkg::req_addr_t    be_dst_addr_o,
    output dma_req_pkg::axi_id_t      be_axi_id_o,
    output dma_req_pkg::burst_t       be_src_burst_o,
    output dma_req_pkg::burst_t       be_dst_burst_o,
    output dma_req_pkg::cache_t       be_src_cache_o,
    output dma_req_pkg::cache_t       be_dst_cache_o,
    output logic                      be_decouple_aw_o,
    output logic                      be_decouple_rw_o,
    output logic                      be_reduce_len_o,
    input  wire                       be_done_i,
    // interrupt
    output logic                      irq_o
);
    import desc64_pkg::*;

    // controller to fetcher
    logic        fetch_start;
    addr_t       fetch_addr;
    // fetcher to reshaper and controller
    logic        desc_valid;
    descriptor_t descriptor;
    // reshaper to controller
    addr_t       next_addr;
    logic        do_irq;

    desc64_fetcher i_fetcher (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_start_i (fetch_start),
        .fetch_addr_i  (fetch_addr),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rdata_i   (mem_rdata_i),
        .desc_valid_o  (desc_valid),
        .descriptor_o  (descriptor)
    );

    // reads the held descriptor, fields stay put until the next fetch
    desc64_reshaper i_reshaper (
        .descriptor_i  (descriptor),
        .length_o      (be_length_o),
        .src_addr_o    (be_src_addr_o),
        .dst_addr_o    (be_dst_addr_o),
        .next_addr_o   (next_addr),
        .axi_id_o      (be_axi_id_o),
        .src_burst_o   (be_src_burst_o),
        .dst_burst_o   (be_dst_burst_o),
        .src_cache_o   (be_src_cache_o),
        .dst_cache_o   (be_dst_cache_o),
        .decouple_aw_o (be_decouple_aw_o),
        .decouple_rw_o (be_decouple_rw_o),
        .reduce_len_o  (be_reduce_len_o),
        .do_irq_o      (do_irq)
    );

    desc64_chain_ctrl i_chain_ctrl (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .doorbell_i      (doorbell_i),
        .doorbell_addr_i (doorbell_addr_i),
        .busy_o          (busy_o),
        .fetch_start_o   (fetch_start),
        .fetch_addr_o    (fetch_addr),
        .desc_valid_i    (desc_valid),
        .next_addr_i     (next_addr),
        .do_irq_i        (do_irq),
        .be_req_valid_o  (be_req_valid_o),
        .be_done_i       (be_done_i),
        .irq_o           (irq_o)
    );

endmodule

`default_nettype wire

// ==== source/desc64_pkg.sv ====
// ----------------------------------------------------------------------
// descriptor format of the chain DMA frontend
// field types, word slots, flag bit positions and end-of-chain marker
// ----------------------------------------------------------------------
`default_nettype none

package desc64_pkg;

    // basic field widths
    localparam int unsigned ADDR_W   = 64;
    localparam int unsigned WORD_W   = 64;
    localparam int unsigned LENGTH_W = 32;
    localparam int unsigned FLAGS_W  = 32;

    // a descriptor is four 64-bit words, 32 bytes in memory
    localparam int unsigned DESC_WORDS = 4;
    localparam int unsigned WORD_BYTES = WORD_W / 8;
    localparam int unsigned DESC_W     = DESC_WORDS * WORD_W;
    localparam int unsigned WORD_IDX_W = $clog2(DESC_WORDS);

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [LENGTH_W-1:0]   length_t;
    typedef logic [FLAGS_W-1:0]    flags_t;
    typedef logic [DESC_W-1:0]     descriptor_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    // word slots inside the descriptor
    // word 0 holds flags in the upper half, length in the lower half
    localparam int unsigned WORD_CTRL = 0;
    localparam int unsigned WORD_NEXT = 1;
    localparam int unsigned WORD_SRC  = 2;
    localparam int unsigned WORD_DST  = 3;

    // flag field positions, lsb of each field
    localparam int unsigned FLAG_IRQ         = 0;
    localparam int unsigned FLAG_SRC_BURST   = 1;
    localparam int unsigned FLAG_DST_BURST   = 3;
    localparam int unsigned FLAG_DECOUPLE_RW = 5;
    localparam int unsigned FLAG_DECOUPLE_AW = 6;
    localparam int unsigned FLAG_REDUCE_LEN  = 7;
    localparam int unsigned FLAG_SRC_CACHE   = 8;
    localparam int unsigned FLAG_DST_CACHE   = 12;
    localparam int unsigned FLAG_AXI_ID      = 16;

    // next pointer value that terminates a chain
    localparam addr_t END_OF_CHAIN = '1;

endpackage

`default_nettype wire

// ==== source/desc64_reshaper.sv ====
// ----------------------------------------------------------------------
// descriptor to backend request mapping, purely combinational
// also yields the next descriptor address and the irq decision
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module desc64_reshaper (
    input  wire desc64_pkg::descriptor_t descriptor_i,
    output dma_req_pkg::req_length_t     length_o,
    output dma_req_pkg::req_addr_t       src_addr_o,
    output dma_req_pkg::req_addr_t       dst_addr_o,
    output desc64_pkg::addr_t            next_addr_o,
    output dma_req_pkg::axi_id_t         axi_id_o,
    output dma_req_pkg::burst_t          src_burst_o,
    output dma_req_pkg::burst_t          dst_burst_o,
    output dma_req_pkg::cache_t          src_cache_o,
    output dma_req_pkg::cache_t          dst_cache_o,
    output logic                         decouple_aw_o,
    output logic                         decouple_rw_o,
    output logic                         reduce_len_o,
    output logic                         do_irq_o
);
    import desc64_pkg::*;
    import dma_req_pkg::*;

    word_t  ctrl_word;
    flags_t flags;

    // split word 0 into flags and length
    assign ctrl_word = descriptor_i[WORD_CTRL*WORD_W +: WORD_W];
    assign flags     = ctrl_word[LENGTH_W +: FLAGS_W];
    assign length_o  = ctrl_word[0 +: LENGTH_W];

    // remaining words map one to one
    assign next_addr_o = descriptor_i[WORD_NEXT*WORD_W +: WORD_W];
    assign src_addr_o  = descriptor_i[WORD_SRC*WORD_W +: WORD_W];
    assign dst_addr_o  = descriptor_i[WORD_DST*WORD_W +: WORD_W];

    // AXI options from the flag word
    assign axi_id_o    = flags[FLAG_AXI_ID +: AXI_ID_W];
    assign src_burst_o = flags[FLAG_SRC_BURST +: BURST_W];
    assign dst_burst_o = flags[FLAG_DST_BURST +: BURST_W];
    assign src_cache_o = flags[FLAG_SRC_CACHE +: CACHE_W];
    assign dst_cache_o = flags[FLAG_DST_CACHE +: CACHE_W];

    // backend options with one reduce-len bit shared by both sides
    assign decouple_aw_o = flags[FLAG_DECOUPLE_AW];
    assign decouple_rw_o = flags[FLAG_DECOUPLE_RW];
    assign reduce_len_o  = flags[FLAG_REDUCE_LEN];

    assign do_irq_o = flags[FLAG_IRQ];

endmodule

`default_nettype wire

// ==== source/dma_req_pkg.sv ====
// ----------------------------------------------------------------------
// transfer backend request fields
// id, burst and cache types, address and length taken from descriptor
// ----------------------------------------------------------------------
`default_nettype none

package dma_req_pkg;

    // AXI side option widths
    localparam int unsigned AXI_ID_W = 8;
    localparam int unsigned BURST_W  = 2;
    localparam int unsigned CACHE_W  = 4;

    // transaction id of the backend AXI requests
    typedef logic [AXI_ID_W-1:0] axi_id_t;

    // AXI burst type, same encoding on both sides
    typedef logic [BURST_W-1:0] burst_t;

    // AXI cache attributes
    typedef logic [CACHE_W-1:0] cache_t;

    // transfer addresses and byte count have the descriptor widths
    typedef desc64_pkg::addr_t   req_addr_t;
    typedef desc64_pkg::length_t req_length_t;

    // lock, prot, qos, region and max burst length are fixed at zero
    // and are not carried on the request at all,
    // the backend ties them off on its side

endpackage

`default_nettype wire

// ==== verification/tb_desc64_frontend.sv ====
// ----------------------------------------------------------------------
// testbench for the descriptor chain DMA frontend
// random chains, memory and backend models, request and irq checker
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_desc64_frontend;

    localparam logic [31:0] SEED       = 32'd56;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam int unsigned CHAINS     = 40;
    localparam int unsigned BUSY_LIMIT = 4000;

    // DUT inputs with the model driven ones starting low
    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        doorbell_i;
    logic [63:0] doorbell_addr_i;
    logic        mem_rvalid_i = 1'b0;
    logic [63:0] mem_rdata_i = '0;
    logic        be_done_i = 1'b0;

    // DUT outputs
    logic        busy_o;
    logic        mem_req_o;
    logic [63:0] mem_addr_o;
    logic        be_req_valid_o;
    logic [31:0] be_length_o;
    logic [63:0] be_src_addr_o;
    logic [63:0] be_dst_addr_o;
    logic [7:0]  be_axi_id_o;
    logic [1:0]  be_src_burst_o;
    logic [1:0]  be_dst_burst_o;
    logic [3:0]  be_src_cache_o;
    logic [3:0]  be_dst_cache_o;
    logic        be_decouple_aw_o;
    logic        be_decouple_rw_o;
    logic        be_reduce_len_o;
    logic        irq_o;

    // all request fields side by side
    logic [182:0] be_now;

    // memory image and reference queues
    logic [63:0]  mem [logic [63:0]];
    logic [63:0]  read_q [$];
    logic [255:0] expect_q [$];

    // separate generator states for stimulus and models
    logic [31:0] stim_lfsr  = SEED;
    logic [31:0] model_lfsr = SEED;

    int unsigned error_count        = 0;
    int unsigned model_reqs         = 0;
    int unsigned model_irqs         = 0;
    int unsigned req_seen           = 0;
    int unsigned irq_seen           = 0;
    int unsigned chain_irq_expected = 0;
    int unsigned chain_irq_seen     = 0;

    // model state
    logic         rd_open    = 1'b0;
    int unsigned  rd_wait    = 0;
    logic [63:0]  rd_data    = '0;
    logic         be_open    = 1'b0;
    int unsigned  be_wait    = 0;
    logic [182:0] be_held    = '0;
    logic         irq_window = 1'b0;
    logic         irq_due    = 1'b0;
    logic         last_due   = 1'b0;

    always #10 clk_i = ~clk_i;

    desc64_frontend u_desc64_frontend (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .doorbell_i       (doorbell_i),
        .doorbell_addr_i  (doorbell_addr_i),
        .busy_o           (busy_o),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_rdata_i      (mem_rdata_i),
        .be_req_valid_o   (be_req_valid_o),
        .be_length_o      (be_length_o),
        .be_src_addr_o    (be_src_addr_o),
        .be_dst_addr_o    (be_dst_addr_o),
        .be_axi_id_o      (be_axi_id_o),
        .be_src_burst_o   (be_src_burst_o),
        .be_dst_burst_o   (be_dst_burst_o),
        .be_src_cache_o   (be_src_cache_o),
        .be_dst_cache_o   (be_dst_cache_o),
        .be_decouple_aw_o (be_decouple_aw_o),
        .be_decouple_rw_o (be_decouple_rw_o),
        .be_reduce_len_o  (be_reduce_len_o),
        .be_done_i        (be_done_i),
        .irq_o            (irq_o)
    );

    assign be_now = {be_length_o, be_src_addr_o, be_dst_addr_o, be_axi_id_o,
                     be_src_burst_o, be_dst_burst_o, be_src_cache_o, be_dst_cache_o,
                     be_decouple_aw_o, be_decouple_rw_o, be_reduce_len_o};

    // galois LFSR stepped once per bit taken
    function automatic logic [63:0] take_bits(inout logic [31:0] state, input int unsigned n);
        logic [63:0] bits;
        logic        lsb;
        int unsigned i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lsb   = state[0];
            state = state >> 1;
            if (lsb) begin
                state = state ^ LFSR_TAPS;
            end
            bits = {bits[62:0], lsb};
        end
        return bits;
    endfunction

    // word 0 = {flags, length}, word 1 next, word 2 src, word 3 dst
    function automatic logic [182:0] expected_fields(input logic [255:0] desc);
        logic [63:0] w0;
        logic [31:0] flags;
        w0    = desc[63:0];
        flags = w0[63:32];
        return {w0[31:0], desc[191:128], desc[255:192], flags[23:16], flags[2:1],
                flags[4:3], flags[11:8], flags[15:12], flags[6], flags[5], flags[7]};
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    // random chain of 1 to 5 descriptors at 32 byte aligned addresses
    task automatic build_chain(output logic [63:0] head);
        int unsigned n;
        int unsigned k;
        logic [63:0] addrs [5];
        logic [63:0] a;
        logic [63:0] w0;
        logic [63:0] w1;
        logic [63:0] w2;
        logic [63:0] w3;
        mem.delete();
        chain_irq_expected = 0;
        chain_irq_seen     = 0;
        n = 1 + take_bits(stim_lfsr, 8) % 5;
        for (k = 0; k < n; k++) begin
            // reserve the base so no two descriptors share it
            do begin
                a = 64'h1000_0000 | (take_bits(stim_lfsr, 19) << 5);
            end while (mem.exists(a));
            mem[a]   = '0;
            addrs[k] = a;
        end
        for (k = 0; k < n; k++) begin
            w0 = take_bits(stim_lfsr, 64);
            w1 = (k == n - 1) ? 64'hFFFF_FFFF_FFFF_FFFF : addrs[k + 1];
            w2 = take_bits(stim_lfsr, 64);
            w3 = take_bits(stim_lfsr, 64);
            mem[addrs[k]]      = w0;
            mem[addrs[k] + 8]  = w1;
            mem[addrs[k] + 16] = w2;
            mem[addrs[k] + 24] = w3;
            read_q.push_back(addrs[k]);
            read_q.push_back(addrs[k] + 8);
            read_q.push_back(addrs[k] + 16);
            read_q.push_back(addrs[k] + 24);
            expect_q.push_back({w3, w2, w1, w0});
            model_reqs++;
            if (w0[32]) begin
                chain_irq_expected++;
                model_irqs++;
            end
        end
        head = addrs[0];
    endtask

    task automatic wait_busy(input logic level, output logic ok);
        int unsigned cycles;
        cycles = 0;
        ok     = 1'b1;
        while (busy_o !== level && ok) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > BUSY_LIMIT) begin
                ok = 1'b0;
                $display("timeout: busy_o did not reach %0b within %0d cycles", level, BUSY_LIMIT);
            end
        end
    endtask

    // memory, backend and irq models acting on the falling edge
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            mem_rvalid_i = 1'b0;
            if (rd_open) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i  = rd_data;
                    rd_open      = 1'b0;
                end
            end
            if (mem_req_o === 1'b1) begin
                if (rd_open) begin
                    report_error("read issued while another read is open");
                end
                if (read_q.size() == 0) begin
                    report_error($sformatf("read of %h beyond the end of chain", mem_addr_o));
                end else if (mem_addr_o !== read_q[0]) begin
                    report_error($sformatf("read address %h, expected %h", mem_addr_o,
                                           read_q[0]));
                    void'(read_q.pop_front());
                end else begin
                    void'(read_q.pop_front());
                end
                rd_data = mem.exists(mem_addr_o) ? mem[mem_addr_o] : ~mem_addr_o;
                rd_wait = 1 + take_bits(model_lfsr, 3);
                rd_open = 1'b1;
            end

            be_done_i = 1'b0;
            // irq and busy are due one cycle after done
            if (irq_window) begin
                if (irq_o !== irq_due) begin
                    report_error($sformatf("irq_o %b after done, expected %b", irq_o, irq_due));
                end
                if (irq_o === 1'b1) begin
                    irq_seen++;
                    chain_irq_seen++;
                end
                if (busy_o !== !last_due) begin
                    report_error($sformatf("busy_o %b after done, expected %b", busy_o,
                                           !last_due));
                end
                irq_window = 1'b0;
            end else if (irq_o !== 1'b0) begin
                report_error("irq_o outside the cycle after a backend done");
            end
            if (be_open) begin
                if (be_now !== be_held) begin
                    report_error("request fields changed before be_done_i");
                end
                be_wait--;
                if (be_wait == 0) begin
                    be_done_i  = 1'b1;
                    be_open    = 1'b0;
                    irq_window = 1'b1;
                end
            end
            if (be_req_valid_o === 1'b1) begin
                req_seen++;
                if (be_open) begin
                    report_error("request issued while another is outstanding");
                end
                if (expect_q.size() == 0) begin
                    report_error("request without an expected descriptor");
                    irq_due  = 1'b0;
                    last_due = 1'b1;
                end else begin
                    if (be_now !== expected_fields(expect_q[0])) begin
                        report_error($sformatf("request fields %h, expected %h", be_now,
                                               expected_fields(expect_q[0])));
                    end
                    irq_due  = expect_q[0][32];
                    last_due = (expect_q[0][127:64] == 64'hFFFF_FFFF_FFFF_FFFF);
                    void'(expect_q.pop_front());
                end
                be_held = be_now;
                be_wait = 1 + take_bits(model_lfsr, 4) % 10;
                be_open = 1'b1;
            end
        end
    end

    initial begin
        int unsigned chain;
        int unsigned gap;
        logic [63:0] head;
        logic        ok;
        logic        timed_out;
        timed_out       = 1'b0;
        rst_n_i         = 1'b0;
        doorbell_i      = 1'b0;
        doorbell_addr_i = '0;
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;

        // quiet outputs until the first doorbell
        repeat (8) begin
            @(negedge clk_i);
            if ({busy_o, mem_req_o, be_req_valid_o, irq_o} !== 4'b0000) begin
                report_error("outputs not low after reset");
            end
        end

        for (chain = 0; chain < CHAINS; chain++) begin
            build_chain(head);
            doorbell_i      = 1'b1;
            doorbell_addr_i = head;
            @(negedge clk_i);
            doorbell_i = 1'b0;
            if (busy_o !== 1'b1) begin
                report_error("busy_o not high the cycle after the doorbell");
            end
            @(negedge clk_i);
            if (mem_req_o !== 1'b1) begin
                report_error("first read not two cycles after the doorbell");
            end
            // a strobe while busy must be dropped
            if (take_bits(stim_lfsr, 1)) begin
                gap = take_bits(stim_lfsr, 4);
                repeat (gap) @(negedge clk_i);
                if (busy_o === 1'b1) begin
                    doorbell_i      = 1'b1;
                    doorbell_addr_i = 64'h2000_0000 | (take_bits(stim_lfsr, 16) << 5);
                    @(negedge clk_i);
                    doorbell_i = 1'b0;
                end
            end
            wait_busy(1'b0, ok);
            if (!ok) begin
                timed_out = 1'b1;
                break;
            end
            // let the irq window of the last descriptor close
            @(negedge clk_i);
            if (read_q.size() != 0 || expect_q.size() != 0) begin
                report_error($sformatf("chain %0d ended with %0d reads, %0d requests left",
                                       chain, read_q.size(), expect_q.size()));
                read_q.delete();
                expect_q.delete();
            end
            if (chain_irq_seen != chain_irq_expected) begin
                report_error($sformatf("chain %0d irq count %0d, expected %0d", chain,
                                       chain_irq_seen, chain_irq_expected));
            end
        end

        if (!timed_out && (req_seen != model_reqs || irq_seen != model_irqs)) begin
            report_error("request or irq totals differ from the model");
        end
        $display("errors %0d, requests %0d of %0d, irqs %0d of %0d", error_count, req_seen,
                 model_reqs, irq_seen, model_irqs);
        if (error_count == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
